// ==== source/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // Word geometry.
    localparam int WORD_BITS  = 32;
    localparam int WORD_BYTES = WORD_BITS / 8;

    typedef logic [WORD_BITS-1:0] word_t;

    // First instruction lives at byte 4, word 0 is left unused.
    localparam word_t RESET_PC = 32'h0000_0004;

    // Primary opcode field, instr[31:26].
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // Function field of SPECIAL, instr[5:0].
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_WRITEBACK,
        ST_HALTED
    } core_state_e;

endpackage

`default_nettype wire

// ==== source/avalon_if.sv ====
`default_nettype none

interface avalon_if;
    import mips_pkg::*;

    word_t address;
    logic  read;
    logic  write;
    word_t writedata;
    word_t readdata;
    logic  waitrequest;

    // Core side.
    modport master (
        output address, read, write, writedata,
        input  readdata, waitrequest
    );

    // RAM side.
    modport slave (
        input  address, read, write, writedata,
        output readdata, waitrequest
    );

endinterface

`default_nettype wire

// ==== source/mips_decoder.sv ====
`default_nettype none

module mips_decoder (
    input  mips_pkg::word_t   instr,
    output logic [4:0]        rs,
    output logic [4:0]        rt,
    output logic [4:0]        rd,
    output mips_pkg::word_t   imm,
    output mips_pkg::alu_op_e alu_op,
    output logic              use_imm,
    output logic              reg_write,
    output logic              dest_rt,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch_eq,
    output logic              branch_ne,
    output logic              jump_reg
);
    import mips_pkg::*;

    opcode_e opcode;
    funct_e  funct;
    word_t   imm_sext;
    word_t   imm_zext;

    assign opcode   = opcode_e'(instr[31:26]);
    assign funct    = funct_e'(instr[5:0]);
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    // Register fields sit in fixed positions for every format.
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    always_comb begin
        imm       = imm_sext;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        dest_rt   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jump_reg  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: begin
                        alu_op    = ALU_ADD;
                        reg_write = 1'b1;
                    end
                    FN_SUBU: begin
                        alu_op    = ALU_SUB;
                        reg_write = 1'b1;
                    end
                    FN_AND: begin
                        alu_op    = ALU_AND;
                        reg_write = 1'b1;
                    end
                    FN_OR: begin
                        alu_op    = ALU_OR;
                        reg_write = 1'b1;
                    end
                    FN_SLT: begin
                        alu_op    = ALU_SLT;
                        reg_write = 1'b1;
                    end
                    FN_JR:   jump_reg = 1'b1;
                    default: ; // Includes sll $0, the canonical nop.
                endcase
            end
            OP_ADDIU: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest_rt   = 1'b1;
            end
            OP_ORI, OP_LUI: begin
                imm       = imm_zext;
                alu_op    = (opcode == OP_LUI) ? ALU_LUI : ALU_OR;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest_rt   = 1'b1;
            end
            OP_LW: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                dest_rt   = 1'b1;
                mem_read  = 1'b1;
            end
            OP_SW: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // Compare by subtraction, ALU zero flag decides.
                alu_op    = ALU_SUB;
                branch_eq = (opcode == OP_BEQ);
                branch_ne = (opcode == OP_BNE);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mips_regfile.sv ====
`default_nettype none

module mips_regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs_addr,
    input  logic [4:0]      rt_addr,
    input  logic [4:0]      wr_addr,
    input  logic            wr_en,
    input  mips_pkg::word_t wr_data,
    output mips_pkg::word_t rs_data,
    output mips_pkg::word_t rt_data,
    output mips_pkg::word_t v0
);
    import mips_pkg::*;

    word_t regs [32];

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            // Writes to r0 are dropped.
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 must hold zero through every write the core issues.
    r0_zero_a: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("r0 no longer reads zero");

endmodule

`default_nettype wire

// ==== source/mips_alu.sv ====
`default_nettype none

module mips_alu (
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   result,
    output logic              zero
);
    import mips_pkg::*;

    word_t sum;
    word_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_SLT: begin
                // Signed compare.
                result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            end
            ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Used by BEQ/BNE after a subtract.
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
`default_nettype none

module mips_core (
    input  logic            clk,
    input  logic            rst_n,
    avalon_if.master        bus,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    core_state_e state;
    core_state_e state_d;

    word_t pc;
    word_t next_pc;
    word_t ir;
    word_t a_reg;
    word_t b_reg;
    word_t alu_out;
    word_t mem_data;
    word_t target;
    logic  taken;
    logic  halt_pending;
    logic  bus_done;

    logic [4:0] dec_rs;
    logic [4:0] dec_rt;
    logic [4:0] dec_rd;
    word_t      dec_imm;
    alu_op_e    dec_alu_op;
    logic       dec_use_imm;
    logic       dec_reg_write;
    logic       dec_dest_rt;
    logic       dec_mem_read;
    logic       dec_mem_write;
    logic       dec_branch_eq;
    logic       dec_branch_ne;
    logic       dec_jump_reg;

    word_t rs_data;
    word_t rt_data;
    word_t alu_result;
    logic  alu_zero;

    mips_decoder dec0 (
        .instr(ir), .rs(dec_rs), .rt(dec_rt), .rd(dec_rd), .imm(dec_imm),
        .alu_op(dec_alu_op), .use_imm(dec_use_imm), .reg_write(dec_reg_write),
        .dest_rt(dec_dest_rt), .mem_read(dec_mem_read), .mem_write(dec_mem_write),
        .branch_eq(dec_branch_eq), .branch_ne(dec_branch_ne), .jump_reg(dec_jump_reg)
    );

    mips_regfile rf0 (
        .clk(clk), .rst_n(rst_n), .rs_addr(dec_rs), .rt_addr(dec_rt),
        .wr_addr(dec_dest_rt ? dec_rt : dec_rd),
        .wr_en(state == ST_WRITEBACK && dec_reg_write),
        .wr_data(dec_mem_read ? mem_data : alu_out),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    mips_alu alu0 (
        .op(dec_alu_op), .a(a_reg), .b(dec_use_imm ? dec_imm : b_reg),
        .result(alu_result), .zero(alu_zero)
    );

    // Bus master. Address and data come from registers held for the whole access.
    assign bus.read      = active && (state == ST_FETCH || (state == ST_MEM && dec_mem_read));
    assign bus.write     = active && state == ST_MEM && dec_mem_write;
    assign bus.address   = (state == ST_MEM) ? alu_out : pc;
    assign bus.writedata = b_reg;
    assign bus_done      = (bus.read || bus.write) && !bus.waitrequest;

    always_comb begin
        state_d = state;
        case (state)
            ST_FETCH:     if (bus_done) state_d = ST_DECODE;
            ST_DECODE:    state_d = ST_EXECUTE;
            ST_EXECUTE:   state_d = (dec_mem_read || dec_mem_write) ? ST_MEM : ST_WRITEBACK;
            ST_MEM:       if (bus_done) state_d = ST_WRITEBACK;
            ST_WRITEBACK: state_d = halt_pending ? ST_HALTED : ST_FETCH;
            default:      state_d = ST_HALTED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_FETCH;
            active       <= 1'b0;
            pc           <= RESET_PC;
            next_pc      <= RESET_PC + word_t'(WORD_BYTES);
            halt_pending <= 1'b0;
        end else begin
            state  <= state_d;
            active <= (state_d != ST_HALTED);
            // Delay slot. pc follows next_pc and a branch target lands one instruction later.
            if (state == ST_WRITEBACK) begin
                pc      <= next_pc;
                next_pc <= taken ? target : next_pc + word_t'(WORD_BYTES);
            end
            // Armed as JR $0 retires, so the halt follows its delay slot.
            if (state == ST_WRITEBACK && dec_jump_reg && a_reg == '0) begin
                halt_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH && bus_done) begin
            ir <= bus.readdata;
        end
        if (state == ST_DECODE) begin
            a_reg <= rs_data;
            b_reg <= rt_data;
        end
        if (state == ST_EXECUTE) begin
            alu_out <= alu_result;
            taken   <= dec_jump_reg || (dec_branch_eq && alu_zero)
                       || (dec_branch_ne && !alu_zero);
            // Branch offset is relative to the delay slot address.
            target  <= dec_jump_reg ? a_reg : next_pc + {dec_imm[29:0], 2'b00};
        end
        if (state == ST_MEM && bus_done) begin
            mem_data <= bus.readdata;
        end
    end

    rd_wr_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus.read && bus.write))
        else $error("Bus read and write asserted together");

    // Request must stay put until the RAM releases it.
    addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.read || bus.write) && bus.waitrequest |=> $stable(bus.address))
        else $error("Bus address changed under waitrequest");

endmodule

`default_nettype wire

// ==== source/avalon_ram.sv ====
`default_nettype none

module avalon_ram #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    avalon_if.slave         bus,
    input  logic            load_valid,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_data
);
    import mips_pkg::*;

    localparam int AW    = $clog2(MEM_WORDS);
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    word_t            mem [MEM_WORDS];
    logic [CNT_W-1:0] wait_cnt;
    logic             req;
    logic [AW-1:0]    word_idx;

    assign req      = bus.read || bus.write;
    assign word_idx = bus.address[AW+1:2];

    // Stall each request for WAIT_CYCLES, then one completion cycle.
    assign bus.waitrequest = req && (wait_cnt != CNT_W'(WAIT_CYCLES));
    assign bus.readdata    = mem[word_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (bus.waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Load port works with the core held in reset.
    always_ff @(posedge clk) begin
        if (load_valid) begin
            mem[load_addr] <= load_data;
        end else if (bus.write && !bus.waitrequest) begin
            mem[word_idx] <= bus.writedata;
        end
    end

    aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> bus.address[1:0] == 2'b00)
        else $error("Unaligned bus access");

endmodule

`default_nettype wire

// ==== source/mips_system.sv ====
`default_nettype none

module mips_system #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load_valid,
    input  logic [7:0]      load_addr,
    input  mips_pkg::word_t load_data,
    output logic            active,
    output mips_pkg::word_t register_v0
);

    // Single shared memory bus.
    avalon_if bus0 ();

    mips_core core0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus0.master),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) ram0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus0.slave),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// ==== verif/mips_system_tb.sv ====
`default_nettype none

module mips_system_tb;
    import mips_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int WAIT_CYCLES  = 2;
    localparam int STIM_WORDS   = 512;
    localparam int RESET_CYCLES = 4;
    localparam int START_BOUND  = 8;
    localparam int HALT_HOLD    = 20;

    logic       clk;
    logic       rst_n;
    logic       load_valid;
    logic [7:0] load_addr;
    word_t      load_data;
    logic       active;
    word_t      register_v0;

    word_t stim [STIM_WORDS];
    int    pos;
    int    tests;

    mips_system #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: expected %08h, actual %08h", name, expected, actual));
        end
    endtask

    // Inputs change just after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_active(input logic level, input int bound, input string name);
        int n;
        n = 0;
        while (active !== level) begin
            if (n >= bound) begin
                if (level) begin
                    abort_run($sformatf("%s: core did not start within %0d cycles", name, bound));
                end else begin
                    abort_run($sformatf("%s: core never halted within %0d cycles", name, bound));
                end
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic run_record(input int base, output int next);
        string name;
        word_t expected;
        int    bound;
        int    count;
        name     = $sformatf("%s", stim[base]);
        expected = stim[base + 1];
        bound    = int'(stim[base + 2]);
        count    = int'(stim[base + 3]);
        next     = base + 4 + count;
        if (count < 1 || count > MEM_WORDS - 1 || next > STIM_WORDS) begin
            abort_run($sformatf("%s: bad word count %0d in the program file", name, count));
        end else begin
            rst_n = 1'b0;
            // Program image starts at the reset address, one word per cycle.
            for (int i = 0; i < count; i++) begin
                load_valid = 1'b1;
                load_addr  = 8'(RESET_PC / WORD_BYTES) + 8'(i);
                load_data  = stim[base + 4 + i];
                next_cycle();
            end
            load_valid = 1'b0;
            load_addr  = '0;
            load_data  = '0;
            repeat (RESET_CYCLES) next_cycle();
            check_value({name, " active in reset"}, '0, word_t'(active));
            rst_n = 1'b1;
            wait_for_active(1'b1, START_BOUND, name);
            wait_for_active(1'b0, bound, name);
            check_value({name, " v0"}, expected, register_v0);
            // Halted core must stay put.
            repeat (HALT_HOLD) begin
                next_cycle();
                check_value({name, " active after halt"}, '0, word_t'(active));
                check_value({name, " v0 after halt"}, expected, register_v0);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        pos        = 0;
        tests      = 0;
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim[i] = '0;
        end
        $readmemh("verif/program_input.txt", stim);
        next_cycle();
        // A zero name code ends the record list.
        while (pos + 4 <= STIM_WORDS && stim[pos] != '0) begin
            run_record(pos, pos);
            tests++;
        end
        if (tests == 0) begin
            abort_run("No test records were read from verif/program_input.txt");
        end else begin
            $display("%0d programs checked", tests);
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/mips_pkg.sv
source/avalon_if.sv
source/mips_decoder.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_core.sv
source/avalon_ram.sv
source/mips_system.sv
verif/mips_system_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -sv --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mips_system_tb -Mdir obj_dir -o mips_system_sim -f project.f

status=0
./obj_dir/mips_system_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "No errors" sim.log; then
    exit 1
fi

// ==== verif/program_input.txt ====
// Columns: name code (four ASCII chars), expected $v0, cycle bound, word count,
// then the program words, loaded from byte address 4. A zero name code ends the list.
// Taken BEQ, the delay slot add runs and the two adds after it are skipped.
62726E63 000000E0 00000100 00000007
24020070 10000003 24420070 24420001 24420001 00000008 00000000
// ADDU, SUBU, AND, OR, SLT summed into $v0, then a BNE that falls through.
72747970 0000112A 00000200 00000010
2403000C 24040005 00641021 00642823 00451021 00642824 00451021 00642825
00451021 0083282A 00451021 14630002 24420100 24421000 00000008 00000000
// SW then LW through the stalled bus, plus one.
6D656D72 CAFEF00E 00000100 00000007
3C03CAFE 3463F00D AC030080 8C020080 24420001 00000008 00000000
// LUI and ORI build a constant, writes to r0 are dropped, r0 added into $v0.
636E7374 12348765 00000100 00000007
3C021234 34428765 24000055 3C00FFFF 00401021 00000008 00000000
// Restart after halt, r2 must be cleared by the new reset.
72737472 FFFFFFFE 00000080 00000003
2442FFFE 00000008 00000000
00000000
